/* include/rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// data path and address width
`define RV_XLEN 32

// architectural integer registers, x0 included
`define RV_NREGS 32

// first instruction fetched after reset
`define RV_RESET_PC 32'h0000_0000

// word where test programs leave their result
`define RV_RESULT_ADDR 32'h0000_0100

`endif

/* verilog/rv_pkg.sv */
`include "rv_defines.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0] rv_word_t;
  typedef logic [3:0] rv_sel_t;
  typedef logic [$clog2(`RV_NREGS)-1:0] rv_reg_idx_t;

  // major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_JALR   = 7'b1100111,
    OP_JAL    = 7'b1101111,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_SYSTEM = 7'b1110011,
    OP_AUIPC  = 7'b0010111,
    OP_LUI    = 7'b0110111
  } rv_opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } rv_alu_op_e;

  typedef struct packed {
    // instruction class, at most one set
    logic        lui;
    logic        auipc;
    logic        jal;
    logic        jalr;
    logic        branch;
    logic        load;
    logic        store;
    logic        alu;
    logic        system;
    logic        bad;
    rv_alu_op_e  alu_op;
    // second ALU operand is the immediate
    logic        use_imm;
    logic [2:0]  funct3;
    rv_reg_idx_t rd;
    rv_reg_idx_t rs1;
    rv_reg_idx_t rs2;
    rv_word_t    imm;
    logic        rd_we;
  } rv_insn_t;

  // master side of a Wishbone classic port
  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    rv_word_t adr;
    rv_word_t dat;
    rv_sel_t  sel;
  } rv_wb_req_t;

endpackage

/* verilog/rv_decode.sv */
`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_decode
  import rv_pkg::*;
(
  input  rv_word_t insn_word,
  output rv_insn_t dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  rv_word_t   imm_i;
  rv_word_t   imm_s;
  rv_word_t   imm_b;
  rv_word_t   imm_u;
  rv_word_t   imm_j;

  assign opcode = insn_word[6:0];
  assign funct3 = insn_word[14:12];
  assign funct7 = insn_word[31:25];

  // immediates, all sign-extended from bit 31
  assign imm_i = {{(`RV_XLEN-12){insn_word[31]}}, insn_word[31:20]};
  assign imm_s = {{(`RV_XLEN-12){insn_word[31]}}, insn_word[31:25], insn_word[11:7]};
  assign imm_b = {{(`RV_XLEN-13){insn_word[31]}}, insn_word[31], insn_word[7],
                  insn_word[30:25], insn_word[11:8], 1'b0};
  assign imm_u = {insn_word[31:12], 12'b0};
  assign imm_j = {{(`RV_XLEN-21){insn_word[31]}}, insn_word[31], insn_word[19:12],
                  insn_word[20], insn_word[30:21], 1'b0};

  always_comb begin
    dec        = '0;
    dec.alu_op = ALU_ADD;
    dec.funct3 = funct3;
    dec.rd     = insn_word[11:7];
    dec.rs1    = insn_word[19:15];
    dec.rs2    = insn_word[24:20];

    case (opcode)
      OP_LUI: begin
        dec.lui   = 1'b1;
        dec.imm   = imm_u;
        dec.rd_we = 1'b1;
      end
      OP_AUIPC: begin
        dec.auipc = 1'b1;
        dec.imm   = imm_u;
        dec.rd_we = 1'b1;
      end
      OP_JAL: begin
        dec.jal   = 1'b1;
        dec.imm   = imm_j;
        dec.rd_we = 1'b1;
      end
      OP_JALR: begin
        dec.jalr    = 1'b1;
        dec.imm     = imm_i;
        dec.use_imm = 1'b1;
        dec.rd_we   = 1'b1;
        dec.bad     = (funct3 != 3'b000);
      end
      OP_BRANCH: begin
        dec.branch = 1'b1;
        dec.imm    = imm_b;
        dec.bad    = (funct3[2:1] == 2'b01);
      end
      OP_LOAD: begin
        dec.load    = 1'b1;
        dec.imm     = imm_i;
        dec.use_imm = 1'b1;
        dec.rd_we   = 1'b1;
        // lb lh lw lbu lhu only
        dec.bad     = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
      end
      OP_STORE: begin
        dec.store   = 1'b1;
        dec.imm     = imm_s;
        dec.use_imm = 1'b1;
        dec.bad     = (funct3[2] || funct3 == 3'b011);
      end
      OP_IMM, OP_REG: begin
        dec.alu     = 1'b1;
        dec.use_imm = (opcode == OP_IMM);
        dec.imm     = imm_i;
        dec.rd_we   = 1'b1;
        case (funct3)
          3'b000: dec.alu_op = (opcode == OP_REG && funct7[5]) ? ALU_SUB : ALU_ADD;
          3'b001: dec.alu_op = ALU_SLL;
          3'b010: dec.alu_op = ALU_SLT;
          3'b011: dec.alu_op = ALU_SLTU;
          3'b100: dec.alu_op = ALU_XOR;
          3'b101: dec.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
          3'b110: dec.alu_op = ALU_OR;
          default: dec.alu_op = ALU_AND;
        endcase
        // funct7 only matters for shifts, and for add/sub on register ops
        if (opcode == OP_REG || funct3[1:0] == 2'b01) begin
          if (funct7 == 7'b0100000) begin
            dec.bad = !(funct3 == 3'b101 || (funct3 == 3'b000 && opcode == OP_REG));
          end else begin
            dec.bad = (funct7 != 7'b0000000);
          end
        end
      end
      OP_SYSTEM: begin
        // ecall is the only system instruction kept
        dec.system = (insn_word[31:7] == 25'd0);
        dec.bad    = !dec.system;
      end
      default: begin
        dec.bad = 1'b1;
      end
    endcase

    if (dec.bad) begin
      dec.rd_we = 1'b0;
    end
  end

endmodule

/* verilog/rv_alu.sv */
`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_alu
  import rv_pkg::*;
(
  input  rv_insn_t dec,
  input  rv_word_t rs1_val,
  input  rv_word_t rs2_val,
  output rv_word_t alu_result,
  output logic     branch_taken
);

  rv_word_t                      op_b;
  rv_alu_op_e                    op;
  logic [$clog2(`RV_XLEN)-1:0]   shamt;
  logic                          lt_s;
  logic                          lt_u;
  logic                          cond;

  assign op_b  = dec.use_imm ? dec.imm : rs2_val;
  assign shamt = op_b[$clog2(`RV_XLEN)-1:0];
  // address arithmetic for memory ops and jalr
  assign op    = (dec.load || dec.store || dec.jalr) ? ALU_ADD : dec.alu_op;

  assign lt_s = $signed(rs1_val) < $signed(op_b);
  assign lt_u = rs1_val < op_b;

  always_comb begin
    case (op)
      ALU_ADD:  alu_result = rs1_val + op_b;
      ALU_SUB:  alu_result = rs1_val - op_b;
      ALU_SLL:  alu_result = rs1_val << shamt;
      ALU_SLT:  alu_result = {{(`RV_XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: alu_result = {{(`RV_XLEN-1){1'b0}}, lt_u};
      ALU_XOR:  alu_result = rs1_val ^ op_b;
      ALU_SRL:  alu_result = rs1_val >> shamt;
      ALU_SRA:  alu_result = rv_word_t'($signed(rs1_val) >>> shamt);
      ALU_OR:   alu_result = rs1_val | op_b;
      ALU_AND:  alu_result = rs1_val & op_b;
      default:  alu_result = '0;
    endcase
  end

  // branches never take the immediate, so op_b is rs2 here
  always_comb begin
    case (dec.funct3)
      3'b000:  cond = (rs1_val == op_b);
      3'b001:  cond = (rs1_val != op_b);
      3'b100:  cond = lt_s;
      3'b101:  cond = !lt_s;
      3'b110:  cond = lt_u;
      3'b111:  cond = !lt_u;
      default: cond = 1'b0;
    endcase
  end

  assign branch_taken = dec.branch && cond;

endmodule

/* verilog/rv_lsu.sv */
`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_lsu
  import rv_pkg::*;
(
  input  rv_insn_t dec,
  input  rv_word_t addr,
  input  rv_word_t rs2_val,
  input  rv_word_t rd_dat,
  output rv_word_t store_dat,
  output rv_sel_t  store_sel,
  output rv_word_t load_val
);

  logic [7:0]  ld_byte;
  logic [15:0] ld_half;
  logic        unsigned_ld;

  // funct3[1:0] gives the size, funct3[2] marks unsigned loads
  assign unsigned_ld = dec.funct3[2];

  always_comb begin
    case (dec.funct3[1:0])
      2'b00: begin
        store_dat = {4{rs2_val[7:0]}};
        store_sel = rv_sel_t'(4'b0001 << addr[1:0]);
      end
      2'b01: begin
        store_dat = {2{rs2_val[15:0]}};
        store_sel = addr[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        store_dat = rs2_val;
        store_sel = 4'b1111;
      end
    endcase
  end

  assign ld_byte = rd_dat[8*addr[1:0] +: 8];
  assign ld_half = addr[1] ? rd_dat[31:16] : rd_dat[15:0];

  always_comb begin
    case (dec.funct3[1:0])
      2'b00:   load_val = {{(`RV_XLEN-8){ld_byte[7] & !unsigned_ld}}, ld_byte};
      2'b01:   load_val = {{(`RV_XLEN-16){ld_half[15] & !unsigned_ld}}, ld_half};
      default: load_val = rd_dat;
    endcase
  end

endmodule

/* verilog/rv_regfile.sv */
`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_regfile
  import rv_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  rv_reg_idx_t rs1_idx,
  input  rv_reg_idx_t rs2_idx,
  output rv_word_t    rs1_val,
  output rv_word_t    rs2_val,
  input  logic        we,
  input  rv_reg_idx_t rd_idx,
  input  rv_word_t    rd_wdata
);

  rv_word_t regs [`RV_NREGS];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd_idx != '0) begin
      // x0 is never written, so it keeps its reset zero
      regs[rd_idx] <= rd_wdata;
    end
  end

  assign rs1_val = regs[rs1_idx];
  assign rs2_val = regs[rs2_idx];

endmodule

/* verilog/rv_control.sv */
`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_control
  import rv_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  output rv_wb_req_t wb_req,
  input  logic       wb_ack,
  input  rv_word_t   wb_dat_r,
  output rv_word_t   insn_word,
  input  rv_insn_t   dec,
  input  rv_word_t   rs1_val,
  input  rv_word_t   alu_result,
  input  logic       branch_taken,
  input  rv_word_t   store_dat,
  input  rv_sel_t    store_sel,
  input  rv_word_t   load_val,
  output logic       rd_we,
  output rv_word_t   rd_wdata,
  output rv_word_t   pc,
  output logic       halt
);

  typedef enum logic [2:0] {S_IDLE, S_FETCH, S_EXEC, S_MEM, S_HALT} state_e;

  state_e   state;
  state_e   state_next;
  rv_word_t ir;
  rv_word_t pc_plus4;
  rv_word_t pc_next;
  rv_word_t jalr_sum;
  logic     stop;
  logic     mem_op;
  logic     retire;

  assign insn_word = ir;
  assign pc_plus4  = pc + `RV_XLEN'(4);
  assign jalr_sum  = rs1_val + dec.imm;
  assign stop      = dec.bad || dec.system;
  assign mem_op    = dec.load || dec.store;

  // plain instructions retire at the end of execute, memory ones on the data ack
  assign retire = (state == S_EXEC && !mem_op && !stop) || (state == S_MEM && wb_ack);

  always_comb begin
    if (dec.jal || branch_taken) begin
      pc_next = pc + dec.imm;
    end else if (dec.jalr) begin
      pc_next = {jalr_sum[`RV_XLEN-1:1], 1'b0};
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      S_IDLE: state_next = S_FETCH;
      S_FETCH: begin
        if (wb_ack) begin
          state_next = S_EXEC;
        end
      end
      S_EXEC: begin
        if (stop) begin
          state_next = S_HALT;
        end else if (mem_op) begin
          state_next = S_MEM;
        end else begin
          state_next = S_FETCH;
        end
      end
      // one idle cycle so cyc drops between the data ack and the next fetch
      S_MEM: begin
        if (wb_ack) begin
          state_next = S_IDLE;
        end
      end
      S_HALT: state_next = S_HALT;
      default: state_next = S_IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= S_IDLE;
      pc    <= `RV_RESET_PC;
    end else begin
      state <= state_next;
      if (retire) begin
        pc <= pc_next;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_FETCH && wb_ack) begin
      ir <= wb_dat_r;
    end
  end

  // write-back source
  assign rd_we = retire && dec.rd_we;

  always_comb begin
    if (dec.load) begin
      rd_wdata = load_val;
    end else if (dec.jal || dec.jalr) begin
      rd_wdata = pc_plus4;
    end else if (dec.lui) begin
      rd_wdata = dec.imm;
    end else if (dec.auipc) begin
      rd_wdata = pc + dec.imm;
    end else begin
      rd_wdata = alu_result;
    end
  end

  always_comb begin
    wb_req = '0;
    case (state)
      S_FETCH: begin
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.adr = pc;
        wb_req.sel = 4'b1111;
      end
      S_MEM: begin
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = dec.store;
        wb_req.adr = {alu_result[`RV_XLEN-1:2], 2'b00};
        wb_req.dat = store_dat;
        wb_req.sel = store_sel;
      end
      default: wb_req = '0;
    endcase
  end

  assign halt = (state == S_HALT);

endmodule

/* verilog/rv_core.sv */
`timescale 1ns/100ps

module rv_core
  import rv_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  output rv_wb_req_t wb_req,
  input  logic       wb_ack,
  input  rv_word_t   wb_dat_r,
  output logic       halt
);

  rv_word_t insn_word;
  rv_insn_t dec;
  rv_word_t rs1_val;
  rv_word_t rs2_val;
  rv_word_t alu_result;
  logic     branch_taken;
  rv_word_t store_dat;
  rv_sel_t  store_sel;
  rv_word_t load_val;
  logic     rd_we;
  rv_word_t rd_wdata;

  rv_control u_control (
    .clk          (clk),
    .rst          (rst),
    .wb_req       (wb_req),
    .wb_ack       (wb_ack),
    .wb_dat_r     (wb_dat_r),
    .insn_word    (insn_word),
    .dec          (dec),
    .rs1_val      (rs1_val),
    .alu_result   (alu_result),
    .branch_taken (branch_taken),
    .store_dat    (store_dat),
    .store_sel    (store_sel),
    .load_val     (load_val),
    .rd_we        (rd_we),
    .rd_wdata     (rd_wdata),
    .pc           (),
    .halt         (halt)
  );

  rv_decode u_decode (
    .insn_word (insn_word),
    .dec       (dec)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1_idx  (dec.rs1),
    .rs2_idx  (dec.rs2),
    .rs1_val  (rs1_val),
    .rs2_val  (rs2_val),
    .we       (rd_we),
    .rd_idx   (dec.rd),
    .rd_wdata (rd_wdata)
  );

  rv_alu u_alu (
    .dec          (dec),
    .rs1_val      (rs1_val),
    .rs2_val      (rs2_val),
    .alu_result   (alu_result),
    .branch_taken (branch_taken)
  );

  // data read back from the bus feeds load extraction
  rv_lsu u_lsu (
    .dec       (dec),
    .addr      (alu_result),
    .rs2_val   (rs2_val),
    .rd_dat    (wb_dat_r),
    .store_dat (store_dat),
    .store_sel (store_sel),
    .load_val  (load_val)
  );

endmodule

/* sim/rv_core_props.sv */
`timescale 1ns/100ps

module rv_core_props
  import rv_pkg::*;
(
  input logic       clk,
  input logic       rst,
  input rv_wb_req_t wb_req,
  input logic       wb_ack,
  input logic       halt
);

  a_stb_needs_cyc: assert property (@(posedge clk) disable iff (rst)
    wb_req.stb |-> wb_req.cyc)
    else $error("stb high without cyc");

  // request fields hold until the slave answers
  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    wb_req.stb && !wb_ack |=> $stable(wb_req.adr) && $stable(wb_req.we)
                              && $stable(wb_req.sel) && $stable(wb_req.dat))
    else $error("request changed while waiting for ack");

  a_stb_drops: assert property (@(posedge clk) disable iff (rst)
    wb_req.stb && wb_ack |=> !wb_req.stb)
    else $error("stb still high in the cycle after ack");

  a_halt_quiet: assert property (@(posedge clk) disable iff (rst)
    halt |-> !wb_req.cyc)
    else $error("bus cycle while halted");

endmodule

/* sim/rv_core_tb.sv */
`timescale 1ns/100ps
`include "rv_defines.svh"

module rv_core_tb
  import rv_pkg::*;
;

  localparam int MAX_TESTS = 16;
  localparam int PROG_LEN  = 12;
  localparam int MEM_WORDS = 256;
  localparam int TIMEOUT   = 2000;
  localparam rv_word_t DATA_ADDR = 32'h0000_0080;
  localparam rv_word_t DATA_WORD = 32'hA5C3_7E81;

  logic       clk;
  logic       rst;
  rv_wb_req_t wb_req;
  logic       wb_ack;
  rv_word_t   wb_dat_r;
  logic       halt;

  rv_word_t mem [MEM_WORDS];
  logic [15:0] lfsr_state;
  int       wait_left;
  logic     store_seen;
  rv_word_t last_dat;
  rv_sel_t  last_sel;

  // test table
  string    names [MAX_TESTS];
  rv_word_t prog [MAX_TESTS][PROG_LEN];
  rv_word_t exp_word [MAX_TESTS];
  rv_sel_t  exp_sel [MAX_TESTS];
  logic     exp_halt [MAX_TESTS];
  int       n_tests;
  int       n_words;
  int       errors;
  int       pass_count;
  int       fail_count;

  rv_core dut (
    .clk      (clk),
    .rst      (rst),
    .wb_req   (wb_req),
    .wb_ack   (wb_ack),
    .wb_dat_r (wb_dat_r),
    .halt     (halt)
  );

  bind rv_core rv_core_props u_props (
    .clk    (clk),
    .rst    (rst),
    .wb_req (wb_req),
    .wb_ack (wb_ack),
    .halt   (halt)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // galois lfsr stepped once per random bit
  function automatic int draw_bits(input int n);
    int value;
    value = 0;
    for (int i = 0; i < n; i++) begin
      value = (value << 1) | lfsr_state[0];
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
    end
    return value;
  endfunction

  // wishbone slave with 0 to 3 wait cycles per request
  always @(negedge clk) begin
    int idx;
    if (rst) begin
      wb_ack = 1'b0;
      wait_left = -1;
    end else if (wb_ack) begin
      wb_ack = 1'b0;
    end else if (wb_req.cyc && wb_req.stb) begin
      if (wait_left < 0) begin
        wait_left = draw_bits(2);
      end
      if (wait_left == 0) begin
        idx = wb_req.adr[9:2];
        if (wb_req.we) begin
          for (int l = 0; l < 4; l++) begin
            if (wb_req.sel[l]) begin
              mem[idx][8*l +: 8] = wb_req.dat[8*l +: 8];
            end
          end
          if (wb_req.adr == `RV_RESULT_ADDR) begin
            store_seen = 1'b1;
            last_dat = wb_req.dat;
            last_sel = wb_req.sel;
          end
        end
        wb_dat_r = mem[idx];
        wb_ack = 1'b1;
        wait_left = -1;
      end else begin
        wait_left--;
      end
    end
  end

  function automatic rv_word_t enc_r(input int f7, rs2, rs1, f3, rd);
    return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'h33};
  endfunction

  function automatic rv_word_t enc_i(input logic [11:0] imm, input int rs1, f3, rd,
                                     input logic [6:0] op);
    return {imm, 5'(rs1), 3'(f3), 5'(rd), op};
  endfunction

  function automatic rv_word_t enc_s(input logic [11:0] imm, input int rs2, rs1, f3);
    return {imm[11:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:0], 7'h23};
  endfunction

  function automatic rv_word_t enc_b(input logic [12:0] imm, input int rs2, rs1, f3);
    return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic rv_word_t enc_u(input logic [19:0] imm, input int rd,
                                     input logic [6:0] op);
    return {imm, 5'(rd), op};
  endfunction

  function automatic rv_word_t enc_j(input logic [20:0] imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'(rd), 7'h6f};
  endfunction

  function automatic rv_word_t addi(input int rd, rs1, input logic [11:0] imm);
    return enc_i(imm, rs1, 0, rd, 7'h13);
  endfunction

  task automatic begin_test(input string name);
    names[n_tests] = name;
    n_words = 0;
    for (int k = 0; k < PROG_LEN; k++) begin
      prog[n_tests][k] = '0;
    end
  endtask

  task automatic emit(input rv_word_t w);
    prog[n_tests][n_words] = w;
    n_words++;
  endtask

  task automatic end_test(input rv_word_t word, input rv_sel_t sel, input logic hlt);
    exp_word[n_tests] = word;
    exp_sel[n_tests] = sel;
    exp_halt[n_tests] = hlt;
    n_tests++;
  endtask

  task automatic compare_word(input string name, input rv_word_t expected,
                              input rv_word_t actual);
    if (expected !== actual) begin
      $display("Mismatch %s: expected word %08h, actual %08h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic compare_sel(input string name, input rv_sel_t expected,
                             input rv_sel_t actual);
    if (expected !== actual) begin
      $display("Mismatch %s: expected sel %04b, actual %04b", name, expected, actual);
      errors++;
    end
  endtask

  task automatic build_table();
    n_tests = 0;
    begin_test("alu_ops");
    emit(addi(1, 0, -7));
    emit(addi(2, 0, 3));
    emit(enc_r(7'h20, 2, 1, 0, 3));
    emit(enc_r(7'h20, 2, 3, 5, 4));
    emit(enc_r(0, 2, 1, 2, 5));
    emit(enc_r(0, 1, 2, 3, 6));
    emit(enc_i(12'd4, 5, 1, 7, 7'h13));
    emit(enc_r(0, 7, 4, 4, 8));
    emit(enc_r(0, 6, 8, 0, 8));
    emit(addi(10, 0, 256));
    emit(enc_s(0, 8, 10, 2));
    emit(32'h0000_0073);
    end_test(32'hFFFF_FFEF, 4'b1111, 1'b1);
    begin_test("lui_auipc");
    emit(enc_u(20'h12345, 1, 7'h37));
    emit(enc_u(20'h00001, 2, 7'h17));
    emit(enc_r(0, 2, 1, 0, 3));
    emit(addi(10, 0, 256));
    emit(enc_s(0, 3, 10, 2));
    emit(32'h0000_0073);
    end_test(32'h1234_6004, 4'b1111, 1'b1);
    begin_test("branch_jump");
    emit(addi(1, 0, 5));
    emit(addi(2, 0, 5));
    emit(enc_b(13'd8, 2, 1, 0));
    emit(addi(3, 0, 1));
    emit(enc_b(13'd8, 2, 1, 1));
    emit(enc_j(21'd8, 4));
    emit(addi(3, 3, 2));
    emit(enc_i(12'd8, 4, 0, 5, 7'h67));
    emit(enc_r(0, 5, 4, 0, 6));
    // x3 stays zero unless a skipped instruction ran
    emit(enc_r(0, 3, 6, 0, 6));
    emit(enc_s(12'd256, 6, 0, 2));
    emit(32'h0000_0073);
    end_test(32'h0000_0038, 4'b1111, 1'b1);
    // loads from DATA_WORD at 0x80 are folded together with xor
    for (int v = 0; v < 3; v++) begin
      begin_test(v == 0 ? "load_byte_a" : (v == 1 ? "load_byte_b" : "load_half"));
      emit(addi(1, 0, 12'h080));
      emit(enc_i(12'd0, 1, v == 0 ? 0 : (v == 1 ? 4 : 1), 2, 7'h03));
      emit(enc_i(v == 2 ? 12'd2 : 12'd1, 1, v == 0 ? 4 : 1 - (v == 1 ? 1 : 0), 3, 7'h03));
      emit(enc_i(v == 2 ? 12'd0 : 12'd2, 1, v == 0 ? 0 : (v == 1 ? 4 : 5), 4, 7'h03));
      emit(enc_i(v == 2 ? 12'd2 : 12'd3, 1, v == 0 ? 4 : (v == 1 ? 0 : 5), 5, 7'h03));
      emit(enc_r(0, 3, 2, 4, 6));
      emit(enc_r(0, 4, 6, 4, 6));
      emit(enc_r(0, 5, 6, 4, 6));
      emit(addi(10, 0, 256));
      emit(enc_s(0, 6, 10, 2));
      emit(32'h0000_0073);
      end_test(v == 0 ? 32'h0000_0099 : (v == 1 ? 32'hFFFF_FF99 : 32'hFFFF_0000),
               4'b1111, 1'b1);
    end
    begin_test("store_byte_merge");
    emit(addi(1, 0, 12'h080));
    emit(addi(2, 0, -12'h033));
    emit(enc_s(12'd1, 2, 1, 0));
    emit(addi(3, 0, 12'h012));
    emit(enc_s(12'd3, 3, 1, 0));
    emit(enc_i(12'd0, 1, 2, 4, 7'h03));
    emit(addi(10, 0, 256));
    emit(enc_s(0, 4, 10, 2));
    emit(32'h0000_0073);
    end_test(32'h12C3_CD81, 4'b1111, 1'b1);
    begin_test("store_half_merge");
    emit(addi(1, 0, 12'h080));
    emit(addi(2, 0, -12'd2));
    emit(enc_s(12'd2, 2, 1, 1));
    emit(addi(3, 0, 12'h044));
    emit(enc_s(12'd0, 3, 1, 0));
    emit(enc_i(12'd0, 1, 2, 4, 7'h03));
    emit(addi(10, 0, 256));
    emit(enc_s(0, 4, 10, 2));
    emit(32'h0000_0073);
    end_test(32'hFFFE_7E44, 4'b1111, 1'b1);
    begin_test("store_byte_lane");
    emit(addi(10, 0, 256));
    emit(addi(2, 0, 12'h06B));
    emit(enc_s(12'd2, 2, 10, 0));
    emit(32'h0000_0073);
    end_test(32'h6B6B_6B6B, 4'b0100, 1'b1);
    begin_test("store_half_lane");
    emit(addi(10, 0, 256));
    emit(enc_u(20'h12345, 2, 7'h37));
    emit(addi(2, 2, 12'h678));
    emit(enc_s(12'd0, 2, 10, 1));
    emit(32'h0000_0073);
    end_test(32'h5678_5678, 4'b0011, 1'b1);
    begin_test("bad_opcode");
    emit(addi(10, 0, 256));
    emit(addi(1, 0, 12'h077));
    emit(enc_s(0, 1, 10, 2));
    emit(32'hFFFF_FFFF);
    emit(addi(1, 0, 12'h001));
    emit(enc_s(0, 1, 10, 2));
    emit(32'h0000_0073);
    end_test(32'h0000_0077, 4'b1111, 1'b1);
  endtask

  task automatic run_test(input int t);
    int cycles;
    int errors_before;
    @(negedge clk);
    rst = 1'b1;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = 32'h9E37_79B9 * (i + 1);
    end
    for (int k = 0; k < PROG_LEN; k++) begin
      mem[(`RV_RESET_PC >> 2) + k] = prog[t][k];
    end
    mem[DATA_ADDR >> 2] = DATA_WORD;
    store_seen = 1'b0;
    repeat (3) @(negedge clk);
    rst = 1'b0;
    cycles = 0;
    while (!halt && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    errors_before = errors;
    if (exp_halt[t] && !halt) begin
      $display("%s: program never halted within %0d cycles", names[t], TIMEOUT);
      errors++;
    end else if (!store_seen) begin
      $display("%s: program made no store to the result address", names[t]);
      errors++;
    end else begin
      compare_word(names[t], exp_word[t], last_dat);
      compare_sel(names[t], exp_sel[t], last_sel);
    end
    if (errors == errors_before) begin
      pass_count++;
      $display("test %s passed", names[t]);
    end else begin
      fail_count++;
      $display("test %s failed", names[t]);
    end
  endtask

  initial begin
    rst = 1'b1;
    wb_ack = 1'b0;
    wb_dat_r = '0;
    lfsr_state = 16'd34638;
    wait_left = -1;
    store_seen = 1'b0;
    last_dat = '0;
    last_sel = '0;
    errors = 0;
    pass_count = 0;
    fail_count = 0;
    build_table();
    for (int t = 0; t < n_tests; t++) begin
      run_test(t);
    end
    $display("tests passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0 && errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+include
verilog/rv_pkg.sv
verilog/rv_decode.sv
verilog/rv_alu.sv
verilog/rv_lsu.sv
verilog/rv_regfile.sv
verilog/rv_control.sv
verilog/rv_core.sv
sim/rv_core_props.sv
sim/rv_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= rv_core_tb
FILELIST  ?= all.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation, check $(LOG)"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
